// ==== hw/if_pkg.sv ====
// Package with fetch stage widths, pc_mux codes, LFSR and dummy instruction constants

package if_pkg;

  //////////////////////////////////////////////////////////////////////
  // Data path widths
  //////////////////////////////////////////////////////////////////////

  localparam int XLEN     = 32;
  // Upper bits of the trap vector base
  localparam int MTVEC_W  = 25;
  localparam int IRQ_ID_W = 5;

  //////////////////////////////////////////////////////////////////////
  // Next-PC select codes
  //////////////////////////////////////////////////////////////////////

  localparam int PC_MUX_W = 3;

  localparam logic [PC_MUX_W-1:0] PC_BOOT     = 3'd0;
  localparam logic [PC_MUX_W-1:0] PC_JUMP     = 3'd1;
  localparam logic [PC_MUX_W-1:0] PC_BRANCH   = 3'd2;
  localparam logic [PC_MUX_W-1:0] PC_MRET     = 3'd3;
  localparam logic [PC_MUX_W-1:0] PC_TRAP_EXC = 3'd4;
  localparam logic [PC_MUX_W-1:0] PC_TRAP_IRQ = 3'd5;

  //////////////////////////////////////////////////////////////////////
  // Prefetch buffer
  //////////////////////////////////////////////////////////////////////

  // Buffer depth, also the limit on reads in flight
  localparam int FIFO_DEPTH = 2;
  localparam int PTR_W      = $clog2(FIFO_DEPTH);
  // Outstanding and discard counters
  localparam int CNT_W      = 2;

  //////////////////////////////////////////////////////////////////////
  // Dummy instruction insertion
  //////////////////////////////////////////////////////////////////////

  localparam int              LFSR_W    = 16;
  // Nonzero so the Galois LFSR never locks up
  localparam logic [LFSR_W-1:0] LFSR_SEED = 16'hACE1;
  localparam logic [LFSR_W-1:0] LFSR_TAPS = 16'hB400;

  // Real issues between two dummies
  localparam int DUMMY_INTERVAL = 4;
  localparam int DUMMY_CNT_W    = $clog2(DUMMY_INTERVAL) + 1;

  // addi opcode, used with rd = rs1 = x0
  localparam logic [6:0] NOP_OPCODE = 7'b0010011;

endpackage

// ==== hw/fetch_bus_if.sv ====
// Interface for fetch transfers and responses between prefetcher and bus master

`timescale 1ns/1ps

interface fetch_bus_if import if_pkg::*; ();

  // Address phase, valid/ready handshake
  logic            trans_valid;
  logic            trans_ready;
  logic [XLEN-1:0] trans_addr;

  // Response phase, in order and never stalled
  logic            resp_valid;
  logic [XLEN-1:0] resp_rdata;
  logic            resp_err;

  // Prefetcher side
  modport prefetch (
    output trans_valid,
    output trans_addr,
    input  trans_ready,
    input  resp_valid,
    input  resp_rdata,
    input  resp_err
  );

  // Bus master side
  modport bus (
    input  trans_valid,
    input  trans_addr,
    output trans_ready,
    output resp_valid,
    output resp_rdata,
    output resp_err
  );

endinterface

// ==== hw/pc_select.sv ====
// Next fetch address mux and mtvec init strobe

`timescale 1ns/1ps

module pc_select import if_pkg::*; (
  input  logic [PC_MUX_W-1:0] pc_mux_i,
  input  logic                pc_set_i,
  input  logic [XLEN-1:0]     boot_addr_i,
  input  logic [XLEN-1:0]     jump_target_i,
  input  logic [XLEN-1:0]     branch_target_i,
  input  logic [XLEN-1:0]     mepc_i,
  input  logic [MTVEC_W-1:0]  mtvec_addr_i,
  input  logic [IRQ_ID_W-1:0] irq_id_i,
  output logic [XLEN-1:0]     branch_addr_o,
  output logic                csr_mtvec_init_o
);

  logic [XLEN-1:0] target;

  always_comb begin
    // Unused codes fall back to boot
    target = {boot_addr_i[XLEN-1:2], 2'b00};
    case (pc_mux_i)
      PC_BOOT:     target = {boot_addr_i[XLEN-1:2], 2'b00};
      PC_JUMP:     target = jump_target_i;
      PC_BRANCH:   target = branch_target_i;
      // Return to the interrupted instruction
      PC_MRET:     target = mepc_i;
      // All exceptions share the vector base
      PC_TRAP_EXC: target = {mtvec_addr_i, 7'b0};
      // Interrupts are vectored, one word per id
      PC_TRAP_IRQ: target = {mtvec_addr_i, irq_id_i, 2'b00};
      default:     target = {boot_addr_i[XLEN-1:2], 2'b00};
    endcase
  end

  // Instructions are at least halfword aligned
  assign branch_addr_o = {target[XLEN-1:1], 1'b0};

  // CSR file loads mtvec when the core boots
  assign csr_mtvec_init_o = pc_set_i && (pc_mux_i == PC_BOOT);

endmodule

// ==== hw/prefetch_unit.sv ====
// Prefetch unit with address sequencing, read tracking, flush discard and response FIFO

`timescale 1ns/1ps

module prefetch_unit import if_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            pc_set_i,
  input  logic [XLEN-1:0] branch_addr_i,
  input  logic            ready_i,
  input  logic            halt_i,
  output logic            valid_o,
  output logic [XLEN-1:0] instr_o,
  output logic [XLEN-1:0] addr_o,
  output logic            err_o,
  output logic            busy_o,
  fetch_bus_if.prefetch   bus_o
);

  // Fetch sequencing
  logic            fetch_active;
  logic [XLEN-1:0] fetch_addr;
  logic [XLEN-1:0] head_pc;
  logic            accept;

  // Read tracking
  logic [CNT_W-1:0] outst_cnt;
  logic [CNT_W-1:0] outst_nxt;
  logic [CNT_W-1:0] discard_cnt;
  logic [CNT_W-1:0] discard_nxt;
  logic [CNT_W:0]   inflight;
  logic             resp_drop;

  // Response buffer
  logic [XLEN-1:0]  fifo_rdata [FIFO_DEPTH];
  logic             fifo_err   [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] fifo_cnt;
  logic             push;
  logic             pop;

  //////////////////////////////////////////////////////////////////////
  // Request side
  //////////////////////////////////////////////////////////////////////

  // Words buffered plus words still on the bus
  assign inflight = {1'b0, fifo_cnt} + {1'b0, outst_cnt};

  // No request in the redirect cycle itself
  // Every read in flight must have a buffer slot waiting
  assign bus_o.trans_valid = fetch_active && !pc_set_i &&
                             (inflight < (CNT_W+1)'(FIFO_DEPTH));
  assign bus_o.trans_addr  = fetch_addr;
  assign accept            = bus_o.trans_valid && bus_o.trans_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fetch_active <= 1'b0;
      fetch_addr   <= '0;
    end else if (pc_set_i) begin
      fetch_active <= 1'b1;
      fetch_addr   <= branch_addr_i;
    end else if (accept) begin
      fetch_addr   <= fetch_addr + XLEN'(4);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Outstanding and discard counters
  //////////////////////////////////////////////////////////////////////

  // Responses of the old path are dropped, including one in the flush cycle
  assign resp_drop = bus_o.resp_valid && (pc_set_i || (discard_cnt != '0));

  always_comb begin
    outst_nxt = outst_cnt;
    if (accept && !bus_o.resp_valid) begin
      outst_nxt = outst_cnt + CNT_W'(1);
    end else if (!accept && bus_o.resp_valid) begin
      outst_nxt = outst_cnt - CNT_W'(1);
    end
  end

  always_comb begin
    discard_nxt = discard_cnt;
    if (pc_set_i) begin
      // Everything still on the bus after this cycle belongs to the old path
      discard_nxt = outst_nxt;
    end else if (bus_o.resp_valid && (discard_cnt != '0)) begin
      discard_nxt = discard_cnt - CNT_W'(1);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outst_cnt   <= '0;
      discard_cnt <= '0;
    end else begin
      outst_cnt   <= outst_nxt;
      discard_cnt <= discard_nxt;
    end
  end

  assign busy_o = (outst_cnt != '0);

  //////////////////////////////////////////////////////////////////////
  // Response FIFO
  //////////////////////////////////////////////////////////////////////

  assign push = bus_o.resp_valid && !resp_drop;
  // Halt keeps the buffered words in place
  assign pop  = valid_o && ready_i && !halt_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fifo_cnt <= '0;
    end else if (pc_set_i) begin
      // Flush
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fifo_cnt <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + PTR_W'(1);
      end
      if (pop) begin
        rd_ptr <= rd_ptr + PTR_W'(1);
      end
      if (push && !pop) begin
        fifo_cnt <= fifo_cnt + CNT_W'(1);
      end else if (pop && !push) begin
        fifo_cnt <= fifo_cnt - CNT_W'(1);
      end
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (push) begin
      fifo_rdata[wr_ptr] <= bus_o.resp_rdata;
      fifo_err[wr_ptr]   <= bus_o.resp_err;
    end
  end

  // PC of the word at the FIFO head
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head_pc <= '0;
    end else if (pc_set_i) begin
      head_pc <= branch_addr_i;
    end else if (pop) begin
      head_pc <= head_pc + XLEN'(4);
    end
  end

  assign valid_o = (fifo_cnt != '0);
  assign instr_o = fifo_rdata[rd_ptr];
  assign err_o   = fifo_err[rd_ptr];
  assign addr_o  = head_pc;

endmodule

// ==== hw/instr_obi_master.sv ====
// OBI instruction bus master with registered address phase and in-order responses

`timescale 1ns/1ps

module instr_obi_master import if_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  fetch_bus_if.bus        trans_i,
  output logic            instr_req_o,
  output logic [XLEN-1:0] instr_addr_o,
  input  logic            instr_gnt_i,
  input  logic            instr_rvalid_i,
  input  logic [XLEN-1:0] instr_rdata_i,
  input  logic            instr_err_i
);

  // Pending address phase
  logic            req_q;
  logic [XLEN-1:0] addr_q;
  logic            accept;

  //////////////////////////////////////////////////////////////////////
  // Address phase
  //////////////////////////////////////////////////////////////////////

  // Free when idle or when the pending request is granted this cycle
  assign trans_i.trans_ready = !req_q || instr_gnt_i;
  assign accept              = trans_i.trans_valid && trans_i.trans_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_q  <= 1'b0;
      addr_q <= '0;
    end else if (accept) begin
      // Back to back transfer when grant and a new request coincide
      req_q  <= 1'b1;
      addr_q <= trans_i.trans_addr;
    end else if (instr_gnt_i) begin
      req_q  <= 1'b0;
    end
  end

  // Request and address stay put until granted
  assign instr_req_o  = req_q;
  assign instr_addr_o = addr_q;

  //////////////////////////////////////////////////////////////////////
  // Response phase
  //////////////////////////////////////////////////////////////////////

  // Slave returns data in request order
  // No stall possible so responses go straight through
  assign trans_i.resp_valid = instr_rvalid_i;
  assign trans_i.resp_rdata = instr_rdata_i;
  assign trans_i.resp_err   = instr_err_i;

endmodule

// ==== hw/dummy_instr.sv ====
// Dummy NOP insertion with issue counter and Galois LFSR immediate

`timescale 1ns/1ps

module dummy_instr import if_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            dummy_en_i,
  input  logic            instr_issued_i,
  input  logic            dummy_issued_i,
  output logic            dummy_insert_o,
  output logic [XLEN-1:0] dummy_word_o
);

  logic [DUMMY_CNT_W-1:0] issue_cnt;
  logic [LFSR_W-1:0]      lfsr_q;
  logic [LFSR_W-1:0]      lfsr_nxt;
  logic                   cnt_wrap;

  //////////////////////////////////////////////////////////////////////
  // Issue counter
  //////////////////////////////////////////////////////////////////////

  // Without insertion the count just wraps around the interval
  assign cnt_wrap = !dummy_en_i && (issue_cnt >= DUMMY_CNT_W'(DUMMY_INTERVAL - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      issue_cnt <= '0;
    end else if (dummy_issued_i) begin
      issue_cnt <= '0;
    end else if (instr_issued_i) begin
      issue_cnt <= cnt_wrap ? '0 : issue_cnt + DUMMY_CNT_W'(1);
    end
  end

  // Request stays up until the dummy issues
  assign dummy_insert_o = dummy_en_i && (issue_cnt == DUMMY_CNT_W'(DUMMY_INTERVAL));

  //////////////////////////////////////////////////////////////////////
  // LFSR
  //////////////////////////////////////////////////////////////////////

  // Right shift, feedback mask applied when bit 0 falls out
  assign lfsr_nxt = (lfsr_q >> 1) ^ (lfsr_q[0] ? LFSR_TAPS : '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lfsr_q <= LFSR_SEED;
    end else if (dummy_issued_i) begin
      lfsr_q <= lfsr_nxt;
    end
  end

  // addi x0, x0, imm with the current LFSR low bits as imm
  assign dummy_word_o = {lfsr_q[11:0], 5'd0, 3'b000, 5'd0, NOP_OPCODE};

endmodule

// ==== hw/if_stage.sv ====
// Instruction fetch stage top level with issue control and IF/ID pipeline register

`timescale 1ns/1ps

module if_stage import if_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,

  // Redirect control and targets
  input  logic [PC_MUX_W-1:0] pc_mux_i,
  input  logic                pc_set_i,
  input  logic [XLEN-1:0]     boot_addr_i,
  input  logic [XLEN-1:0]     jump_target_i,
  input  logic [XLEN-1:0]     branch_target_i,
  input  logic [XLEN-1:0]     mepc_i,
  input  logic [MTVEC_W-1:0]  mtvec_addr_i,
  input  logic [IRQ_ID_W-1:0] irq_id_i,

  // Pipeline control
  input  logic                kill_if_i,
  input  logic                halt_if_i,
  input  logic                dummy_en_i,
  input  logic                id_ready_i,

  // OBI instruction bus
  output logic                instr_req_o,
  output logic [XLEN-1:0]     instr_addr_o,
  input  logic                instr_gnt_i,
  input  logic                instr_rvalid_i,
  input  logic [XLEN-1:0]     instr_rdata_i,
  input  logic                instr_err_i,

  // Stage status
  output logic                if_valid_o,
  output logic [XLEN-1:0]     pc_if_o,
  output logic                if_busy_o,
  output logic                csr_mtvec_init_o,
  output logic                lfsr_shift_o,

  // IF/ID pipeline register
  output logic                id_instr_valid_o,
  output logic [XLEN-1:0]     id_instr_o,
  output logic [XLEN-1:0]     id_pc_o,
  output logic                id_bus_err_o,
  output logic                id_dummy_o
);

  logic [XLEN-1:0] branch_addr;

  // Prefetcher outputs
  logic            prefetch_valid;
  logic [XLEN-1:0] prefetch_instr;
  logic            prefetch_err;

  // Issue control
  logic            issue;
  logic            real_issue;
  logic            dummy_issue;
  logic            dummy_insert;
  logic [XLEN-1:0] dummy_word;

  fetch_bus_if fetch_bus ();

  //////////////////////////////////////////////////////////////////////
  // Fetch path
  //////////////////////////////////////////////////////////////////////

  pc_select pc_select_inst (
    .pc_mux_i         (pc_mux_i),
    .pc_set_i         (pc_set_i),
    .boot_addr_i      (boot_addr_i),
    .jump_target_i    (jump_target_i),
    .branch_target_i  (branch_target_i),
    .mepc_i           (mepc_i),
    .mtvec_addr_i     (mtvec_addr_i),
    .irq_id_i         (irq_id_i),
    .branch_addr_o    (branch_addr),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  prefetch_unit prefetch_unit_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .pc_set_i      (pc_set_i),
    .branch_addr_i (branch_addr),
    .ready_i       (real_issue),
    .halt_i        (halt_if_i),
    .valid_o       (prefetch_valid),
    .instr_o       (prefetch_instr),
    .addr_o        (pc_if_o),
    .err_o         (prefetch_err),
    .busy_o        (if_busy_o),
    .bus_o         (fetch_bus.prefetch)
  );

  instr_obi_master instr_obi_master_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .trans_i        (fetch_bus.bus),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_err_i    (instr_err_i)
  );

  dummy_instr dummy_instr_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .dummy_en_i     (dummy_en_i),
    .instr_issued_i (real_issue),
    .dummy_issued_i (dummy_issue),
    .dummy_insert_o (dummy_insert),
    .dummy_word_o   (dummy_word)
  );

  //////////////////////////////////////////////////////////////////////
  // Issue control
  //////////////////////////////////////////////////////////////////////

  // Kill and halt block issue of both real and dummy words
  assign if_valid_o  = (prefetch_valid || dummy_insert) && !kill_if_i && !halt_if_i;
  assign issue       = if_valid_o && id_ready_i;
  // Dummy takes priority, the prefetched word waits in the FIFO
  assign dummy_issue = issue && dummy_insert;
  assign real_issue  = issue && !dummy_insert;

  // One LFSR step per inserted dummy
  assign lfsr_shift_o = dummy_issue;

  //////////////////////////////////////////////////////////////////////
  // IF/ID pipeline register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_instr_valid_o <= 1'b0;
      id_instr_o       <= '0;
      id_pc_o          <= '0;
      id_bus_err_o     <= 1'b0;
      id_dummy_o       <= 1'b0;
    end else if (issue) begin
      id_instr_valid_o <= 1'b1;
      id_dummy_o       <= dummy_insert;
      if (dummy_insert) begin
        // Dummy reuses the PC already in ID
        id_instr_o   <= dummy_word;
        id_bus_err_o <= 1'b0;
      end else begin
        id_instr_o   <= prefetch_instr;
        id_pc_o      <= pc_if_o;
        id_bus_err_o <= prefetch_err;
      end
    end else if (id_ready_i) begin
      // ID consumed its word and nothing new came in
      id_instr_valid_o <= 1'b0;
    end
  end

endmodule

// ==== dv/instr_mem_model.sv ====
// OBI instruction memory responder with random grant and response delays

`timescale 1ns/1ps

module instr_mem_model import if_pkg::*; #(
  parameter logic [31:0] SEED = 32'h1
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            req_i,
  input  logic [XLEN-1:0] addr_i,
  output logic            gnt_o,
  output logic            rvalid_o,
  output logic [XLEN-1:0] rdata_o,
  output logic            err_o
);

  integer          seed;
  // Granted reads waiting for their response, oldest first
  logic [XLEN-1:0] pend_addr [$];
  int              pend_wait [$];
  int              gnt_wait;
  logic            accepted;
  logic [XLEN-1:0] acc_addr;

  // Address XOR pattern, rotated left by 3
  function automatic logic [XLEN-1:0] read_data(input logic [XLEN-1:0] addr);
    logic [XLEN-1:0] mixed;
    mixed = addr ^ 32'h5A5A_0000;
    return {mixed[XLEN-4:0], mixed[XLEN-1:XLEN-3]};
  endfunction

  // 0 to 3 cycles
  function automatic int rand_delay();
    return $unsigned($random(seed)) % 4;
  endfunction

  initial begin
    seed     = SEED;
    gnt_o    = 1'b0;
    rvalid_o = 1'b0;
    rdata_o  = '0;
    err_o    = 1'b0;
    gnt_wait = rand_delay();
    forever begin
      // Bus is stable mid cycle
      @(negedge clk);
      accepted = rst_n && req_i && gnt_o;
      acc_addr = addr_i;
      @(posedge clk);
      #2;
      if (accepted) begin
        pend_addr.push_back(acc_addr);
        pend_wait.push_back(rand_delay());
        gnt_wait = rand_delay();
      end
      // Address phase, grant after the drawn wait
      gnt_o = req_i && (gnt_wait == 0);
      if (req_i && (gnt_wait != 0)) begin
        gnt_wait = gnt_wait - 1;
      end
      // Response phase, strictly in grant order
      rvalid_o = 1'b0;
      err_o    = 1'b0;
      if (pend_addr.size() > 0) begin
        if (pend_wait[0] == 0) begin
          rvalid_o = 1'b1;
          rdata_o  = read_data(pend_addr[0]);
          // Top 256 MB answer with a bus error
          err_o    = (pend_addr[0][XLEN-1:XLEN-4] == 4'hF);
          void'(pend_addr.pop_front());
          void'(pend_wait.pop_front());
        end else begin
          pend_wait[0] = pend_wait[0] - 1;
        end
      end
    end
  end

endmodule

// ==== dv/if_stage_sva.sv ====
// Bound checker for OBI address phase, response tracking and IF/ID stability

`timescale 1ns/1ps

module if_stage_sva import if_pkg::*; (
  input logic            clk,
  input logic            rst_n,
  input logic            req_i,
  input logic [XLEN-1:0] addr_i,
  input logic            gnt_i,
  input logic            rvalid_i,
  input logic            id_ready_i,
  input logic            id_valid_i,
  input logic [XLEN-1:0] id_instr_i,
  input logic [XLEN-1:0] id_pc_i,
  input logic            id_err_i,
  input logic            id_dummy_i
);

  int             sva_errors = 0;
  // Reads granted on OBI and not yet answered
  logic [CNT_W:0] obi_outst;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      obi_outst <= '0;
    end else begin
      obi_outst <= obi_outst + (CNT_W+1)'(req_i && gnt_i) - (CNT_W+1)'(rvalid_i);
    end
  end

  // Request and address hold until granted
  addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
    req_i && !gnt_i |=> req_i && $stable(addr_i)
  ) else begin
    sva_errors++;
    $error("OBI request dropped or address changed before grant");
  end

  // Every response belongs to a granted read
  rvalid_owed: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid_i |-> (obi_outst != '0)
  ) else begin
    sva_errors++;
    $error("rvalid without an outstanding read");
  end

  // ID stage stalled so the register must not move
  id_hold: assert property (@(posedge clk) disable iff (!rst_n)
    !id_ready_i |=> $stable(id_valid_i) && $stable(id_instr_i) && $stable(id_pc_i) &&
                    $stable(id_err_i) && $stable(id_dummy_i)
  ) else begin
    sva_errors++;
    $error("IF/ID register changed while id_ready_i was low");
  end

endmodule

// ==== dv/if_stage_tb.sv ====
// Testbench for the fetch stage with random stimulus, reference model and compare tasks

`timescale 1ns/1ps

module if_stage_tb import if_pkg::*; ();

  localparam logic [31:0] SEED          = 32'h82b5fb44;
  localparam int          CLK_PERIOD    = 40;
  localparam int          DRIVE_DELAY   = 2;
  localparam int          RESET_CYCLES  = 3;
  localparam int          QUIET_CYCLES  = 8;
  // Plain run, then stress, then stress with dummies
  localparam int          PHASE1_ISSUES = 300;
  localparam int          PHASE2_ISSUES = 1100;
  localparam int          TOTAL_ISSUES  = 2000;
  localparam int          MAX_CYCLES    = 15;
  localparam int          TIMEOUT_CYCLES = TOTAL_ISSUES * MAX_CYCLES;

  logic                clk;
  logic                rst_n;
  logic [PC_MUX_W-1:0] pc_mux_i;
  logic                pc_set_i;
  logic [XLEN-1:0]     boot_addr_i;
  logic [XLEN-1:0]     jump_target_i;
  logic [XLEN-1:0]     branch_target_i;
  logic [XLEN-1:0]     mepc_i;
  logic [MTVEC_W-1:0]  mtvec_addr_i;
  logic [IRQ_ID_W-1:0] irq_id_i;
  logic                kill_if_i;
  logic                halt_if_i;
  logic                dummy_en_i;
  logic                id_ready_i;
  logic                instr_req_o;
  logic [XLEN-1:0]     instr_addr_o;
  logic                instr_gnt_i;
  logic                instr_rvalid_i;
  logic [XLEN-1:0]     instr_rdata_i;
  logic                instr_err_i;
  logic                if_valid_o;
  logic [XLEN-1:0]     pc_if_o;
  logic                if_busy_o;
  logic                csr_mtvec_init_o;
  logic                lfsr_shift_o;
  logic                id_instr_valid_o;
  logic [XLEN-1:0]     id_instr_o;
  logic [XLEN-1:0]     id_pc_o;
  logic                id_bus_err_o;
  logic                id_dummy_o;

  // Reference model state
  integer              seed;
  logic [XLEN-1:0]     next_pc;
  logic [XLEN-1:0]     exp_pc;
  logic [XLEN-1:0]     exp_instr;
  logic                exp_valid;
  logic                exp_err;
  logic                exp_dummy;
  logic                new_word;
  logic                booted;
  logic [LFSR_W-1:0]   lfsr;
  int                  real_cnt;
  int                  issued_cnt;
  int                  cycle_cnt;
  // Granted OBI reads still waiting for rvalid
  int                  bus_outst;

  if_stage if_stage_inst (.*);

  instr_mem_model #(.SEED(SEED)) instr_mem_model_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_i    (instr_req_o),
    .addr_i   (instr_addr_o),
    .gnt_o    (instr_gnt_i),
    .rvalid_o (instr_rvalid_i),
    .rdata_o  (instr_rdata_i),
    .err_o    (instr_err_i)
  );

  bind if_stage if_stage_sva if_stage_sva_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_i      (instr_req_o),
    .addr_i     (instr_addr_o),
    .gnt_i      (instr_gnt_i),
    .rvalid_i   (instr_rvalid_i),
    .id_ready_i (id_ready_i),
    .id_valid_i (id_instr_valid_o),
    .id_instr_i (id_instr_o),
    .id_pc_i    (id_pc_o),
    .id_err_i   (id_bus_err_o),
    .id_dummy_i (id_dummy_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Error handling and compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic stop_on_error();
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped at first error");
  endtask

  task automatic check_word(input string name, input logic [XLEN-1:0] exp,
                            input logic [XLEN-1:0] act);
    if (act !== exp) begin
      $display("FAILED at %0t: %s expected %h actual %h", $time, name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_pc(input string name, input logic [XLEN-1:0] exp,
                          input logic [XLEN-1:0] act);
    if (act !== exp) begin
      $display("FAILED at %0t: %s expected %h actual %h", $time, name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAILED at %0t: %s expected %b actual %b", $time, name, exp, act);
      stop_on_error();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Memory rules, redirect targets and LFSR
  //////////////////////////////////////////////////////////////////////

  function automatic logic [XLEN-1:0] mem_word(input logic [XLEN-1:0] addr);
    logic [XLEN-1:0] mixed;
    mixed = addr ^ 32'h5A5A_0000;
    return {mixed[XLEN-4:0], mixed[XLEN-1:XLEN-3]};
  endfunction

  function automatic logic [XLEN-1:0] expected_target();
    logic [XLEN-1:0] t;
    case (pc_mux_i)
      PC_BOOT:     t = {boot_addr_i[XLEN-1:2], 2'b00};
      PC_JUMP:     t = jump_target_i;
      PC_BRANCH:   t = branch_target_i;
      PC_MRET:     t = mepc_i;
      PC_TRAP_EXC: t = {mtvec_addr_i, 7'b0};
      PC_TRAP_IRQ: t = {mtvec_addr_i, irq_id_i, 2'b00};
      default:     t = '0;
    endcase
    // Fetch targets are halfword aligned
    t[0] = 1'b0;
    return t;
  endfunction

  function automatic logic [LFSR_W-1:0] lfsr_step(input logic [LFSR_W-1:0] v);
    logic [LFSR_W-1:0] s;
    s = v >> 1;
    if (v[0]) begin
      s = s ^ LFSR_TAPS;
    end
    return s;
  endfunction

  function automatic int rand_pct();
    return $unsigned($random(seed)) % 100;
  endfunction

  function automatic logic [XLEN-1:0] rand_addr();
    logic [XLEN-1:0] addr;
    addr = $random(seed);
    // About a quarter of targets land in the error region
    if (rand_pct() < 25) begin
      addr[XLEN-1:XLEN-4] = 4'hF;
    end
    return addr;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic start_redirect(input logic [PC_MUX_W-1:0] mux);
    logic [XLEN-1:0] addr;
    pc_set_i        = 1'b1;
    kill_if_i       = 1'b1;
    pc_mux_i        = mux;
    boot_addr_i     = rand_addr();
    jump_target_i   = rand_addr();
    branch_target_i = rand_addr();
    mepc_i          = rand_addr();
    addr            = rand_addr();
    mtvec_addr_i    = addr[XLEN-1:XLEN-MTVEC_W];
    irq_id_i        = IRQ_ID_W'($random(seed));
  endtask

  task automatic drive_inputs();
    int roll;
    pc_set_i   = 1'b0;
    kill_if_i  = 1'b0;
    halt_if_i  = 1'b0;
    id_ready_i = 1'b1;
    // Enabled once and left on to the end
    dummy_en_i = (issued_cnt >= PHASE2_ISSUES);
    if (cycle_cnt < QUIET_CYCLES) begin
      id_ready_i = rand_pct() < 50;
    end else if (cycle_cnt == QUIET_CYCLES) begin
      start_redirect(PC_BOOT);
    end else if (issued_cnt >= PHASE1_ISSUES) begin
      id_ready_i = rand_pct() < 75;
      halt_if_i  = rand_pct() < 10;
      roll       = rand_pct();
      if (roll < 3) begin
        start_redirect(PC_MUX_W'($unsigned($random(seed)) % 6));
      end else if (roll < 6) begin
        kill_if_i = 1'b1;
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference model run at the falling edge
  //////////////////////////////////////////////////////////////////////

  task automatic check_cycle();
    logic issue;
    logic dummy_due;
    if (if_stage_inst.if_stage_sva_inst.sva_errors != 0) begin
      $display("Bound assertion reported a protocol or stability error at %0t", $time);
      stop_on_error();
    end
    // Register contents loaded at the last edge
    check_flag("id_instr_valid_o", exp_valid, id_instr_valid_o);
    if (new_word) begin
      check_flag("id_dummy_o", exp_dummy, id_dummy_o);
      check_pc("id_pc_o", exp_pc, id_pc_o);
      check_word("id_instr_o", exp_instr, id_instr_o);
      check_flag("id_bus_err_o", exp_err, id_bus_err_o);
    end
    check_flag("csr_mtvec_init_o", pc_set_i && (pc_mux_i == PC_BOOT), csr_mtvec_init_o);
    // Reads waiting for grant or for their response
    check_flag("if_busy_o", instr_req_o || (bus_outst != 0), if_busy_o);
    if (instr_req_o && instr_gnt_i) begin
      bus_outst = bus_outst + 1;
    end
    if (instr_rvalid_i) begin
      bus_outst = bus_outst - 1;
    end
    // Idle until the first redirect
    if (!booted) begin
      check_flag("instr_req_o", 1'b0, instr_req_o);
      check_flag("if_valid_o", 1'b0, if_valid_o);
    end
    if (kill_if_i || halt_if_i) begin
      check_flag("if_valid_o", 1'b0, if_valid_o);
    end
    issue     = if_valid_o && id_ready_i;
    dummy_due = dummy_en_i && (real_cnt == DUMMY_INTERVAL);
    // A pending dummy is offered whenever issue is not blocked
    if (dummy_due && !kill_if_i && !halt_if_i) begin
      check_flag("if_valid_o", 1'b1, if_valid_o);
    end
    // Head of the prefetch buffer is the next PC in program order
    if (if_valid_o && !dummy_due) begin
      check_pc("pc_if_o", next_pc, pc_if_o);
    end
    check_flag("lfsr_shift_o", issue && dummy_due, lfsr_shift_o);
    new_word = issue;
    if (issue) begin
      exp_valid  = 1'b1;
      exp_dummy  = dummy_due;
      issued_cnt = issued_cnt + 1;
      if (dummy_due) begin
        // addi x0, x0, imm and the PC already in ID
        exp_instr = {lfsr[11:0], 5'd0, 3'b000, 5'd0, NOP_OPCODE};
        exp_err   = 1'b0;
        lfsr      = lfsr_step(lfsr);
        real_cnt  = 0;
      end else begin
        exp_pc    = next_pc;
        exp_instr = mem_word(next_pc);
        exp_err   = (next_pc[XLEN-1:XLEN-4] == 4'hF);
        next_pc   = next_pc + 4;
        real_cnt  = dummy_en_i ? real_cnt + 1 : (real_cnt + 1) % DUMMY_INTERVAL;
      end
    end else if (id_ready_i) begin
      exp_valid = 1'b0;
    end
    if (pc_set_i) begin
      next_pc = expected_target();
      booted  = 1'b1;
    end
  endtask

  initial begin
    seed            = SEED;
    rst_n           = 1'b0;
    pc_mux_i        = PC_BOOT;
    pc_set_i        = 1'b0;
    boot_addr_i     = '0;
    jump_target_i   = '0;
    branch_target_i = '0;
    mepc_i          = '0;
    mtvec_addr_i    = '0;
    irq_id_i        = '0;
    kill_if_i       = 1'b0;
    halt_if_i       = 1'b0;
    dummy_en_i      = 1'b0;
    id_ready_i      = 1'b0;
    next_pc         = '0;
    exp_pc          = '0;
    exp_instr       = '0;
    exp_valid       = 1'b0;
    exp_err         = 1'b0;
    exp_dummy       = 1'b0;
    new_word        = 1'b0;
    booted          = 1'b0;
    lfsr            = LFSR_SEED;
    real_cnt        = 0;
    issued_cnt      = 0;
    cycle_cnt       = 0;
    bus_outst       = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    rst_n = 1'b1;
    while (issued_cnt < TOTAL_ISSUES) begin
      drive_inputs();
      @(negedge clk);
      check_cycle();
      @(posedge clk);
      #DRIVE_DELAY;
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
        $display("Timeout after %0d cycles with only %0d of %0d instructions issued",
                 cycle_cnt, issued_cnt, TOTAL_ISSUES);
        stop_on_error();
      end
    end
    if (if_stage_inst.if_stage_sva_inst.sva_errors == 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      $display("Bound assertion reported an error late in the run");
      $display("RESULT: FAIL");
      $fatal(1, "Assertion errors at end of run");
    end
  end

endmodule

// ==== files.f ====
hw/if_pkg.sv
hw/fetch_bus_if.sv
hw/pc_select.sv
hw/prefetch_unit.sv
hw/instr_obi_master.sv
hw/dummy_instr.sv
hw/if_stage.sv
dv/instr_mem_model.sv
dv/if_stage_sva.sv
dv/if_stage_tb.sv
